// ==== filelist.f ====
+incdir+include
verilog/mem_bus_pkg.sv
verilog/icache_pkg.sv
verilog/cache_ram.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/main_mem.sv
verilog/fetch_top.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ************************************************************
// Address and data geometry
// ************************************************************

`define ADDR_W          12      // Word address
`define DATA_W          32

// ************************************************************
// Instruction cache shape
// ************************************************************

`define CACHE_WAYS      4
`define CACHE_SETS      32
`define LINE_WORDS      4

// Field widths of a fetch address
`define OFF_W           2       // log2 of LINE_WORDS
`define SET_W           5       // log2 of CACHE_SETS
`define TAG_W           (`ADDR_W - `SET_W - `OFF_W)
`define LINE_ADDR_W     (`ADDR_W - `OFF_W)

// ************************************************************
// Shared memory
// ************************************************************

`define MEM_DEPTH       4096
`define MEM_LATENCY     3       // Cycles from req seen to first ack

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module fetch_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vfetch_tb > sim.log 2>&1 || echo "Simulator exited with an error status" >> sim.log
cat sim.log

grep -q "Test failures found" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"

// ==== sim/fetch_properties.sv ====
module fetch_properties (
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_ic_req,
    input logic                i_d_req,
    input logic                i_ic_ack,
    input logic                i_d_ack,
    input logic                i_mem_ack,
    input mem_bus_pkg::grant_e i_owner
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] beats;     // Acks seen in the current cache burst

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_ic_req)
            beats <= '0;
        else if (i_ic_ack)
            beats <= beats + 1'b1;
    end

    // ************************************************************
    // Ack routing and grant stability
    // ************************************************************

    // Every memory ack reaches exactly one requester
    mem_ack_routed: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_ack |-> (i_ic_ack != i_d_ack))
        else $error("Memory ack was not routed to exactly one requester");

    ic_ack_owner: assert property (@(posedge i_clk) disable iff (i_rst)
        i_ic_ack |-> (i_owner == mem_bus_pkg::GRANT_ICACHE && i_ic_req))
        else $error("Cache ack while the cache does not own the memory with req high");

    d_ack_owner: assert property (@(posedge i_clk) disable iff (i_rst)
        i_d_ack |-> (i_owner == mem_bus_pkg::GRANT_DATA && i_d_req))
        else $error("Data ack while the data port does not own the memory with req high");

    ic_grant_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_owner == mem_bus_pkg::GRANT_ICACHE && i_ic_req)
            |=> (i_owner == mem_bus_pkg::GRANT_ICACHE))
        else $error("Cache grant changed while its req was high");

    d_grant_held: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_owner == mem_bus_pkg::GRANT_DATA && i_d_req)
            |=> (i_owner == mem_bus_pkg::GRANT_DATA))
        else $error("Data grant changed while its req was high");

    // Burst of four, req dropped only after the last beat
    ic_req_full_burst: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_ic_req) |-> (beats == 3'd4))
        else $error("Cache memory req fell before its fourth ack");

    ic_burst_length: assert property (@(posedge i_clk) disable iff (i_rst)
        i_ic_ack |-> (beats < 3'd4))
        else $error("Cache received more than four acks in one burst");
endmodule

// ==== sim/fetch_tb.sv ====
`include "cache_cfg.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FETCH_TIMEOUT = 200;
    localparam int DATA_TIMEOUT  = 200;
    localparam int LAT_ANY  = 0;
    localparam int LAT_HIT  = 1;
    localparam int LAT_MISS = 2;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   imem_req;
    logic [`ADDR_W-1:0]     imem_addr;
    logic                   imem_next;
    logic                   imem_ack;
    mem_bus_pkg::mem_word_t imem_data;
    logic                   dmem_req;
    logic                   dmem_we;
    mem_bus_pkg::mem_addr_t dmem_addr;
    mem_bus_pkg::mem_word_t dmem_wdata;
    logic                   dmem_ack;
    mem_bus_pkg::mem_word_t dmem_rdata;

    logic [15:0]            lfsr;
    int                     error_count = 0;
    mem_bus_pkg::mem_word_t shadow [`MEM_DEPTH];   // Mirror of every data write
    mem_bus_pkg::mem_addr_t fetch_q [$];           // Fetches awaiting their ack
    mem_bus_pkg::mem_addr_t dq_addr [$];
    logic                   dq_we [$];

    fetch_top fetch_top_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_imem_req   (imem_req),
        .i_imem_addr  (imem_addr),
        .i_imem_next  (imem_next),
        .o_imem_ack   (imem_ack),
        .o_imem_data  (imem_data),
        .i_dmem_req   (dmem_req),
        .i_dmem_we    (dmem_we),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_wdata (dmem_wdata),
        .o_dmem_ack   (dmem_ack),
        .o_dmem_rdata (dmem_rdata)
    );

    bind mem_arbiter fetch_properties fetch_properties_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_ic_req  (i_ic_req),
        .i_d_req   (i_d_req),
        .i_ic_ack  (o_ic_ack),
        .i_d_ack   (o_d_ack),
        .i_mem_ack (i_mem_ack),
        .i_owner   (owner)
    );

    always #10 clk = ~clk;

    // ************************************************************
    // Helpers
    // ************************************************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic mem_bus_pkg::mem_addr_t line_base(input int tag, input int set);
        return mem_bus_pkg::mem_addr_t'(tag * `CACHE_SETS * `LINE_WORDS + set * `LINE_WORDS);
    endfunction

    // Expected word for any address, memory contents as written so far
    function automatic mem_bus_pkg::mem_word_t ref_word(input mem_bus_pkg::mem_addr_t a);
        return shadow[a];
    endfunction

    task automatic stop_run(input string line);
        error_count++;
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic dmem_access(input logic we, input mem_bus_pkg::mem_addr_t addr,
                               input mem_bus_pkg::mem_word_t wdata);
        int cycles;
        @(posedge clk);
        #2;
        dmem_req   = 1'b1;
        dmem_we    = we;
        dmem_addr  = addr;
        dmem_wdata = wdata;
        if (we)
            shadow[addr] = wdata;
        dq_addr.push_back(addr);
        dq_we.push_back(we);
        cycles = 1;
        @(negedge clk);
        while (!dmem_ack) begin
            if (cycles >= DATA_TIMEOUT)
                stop_run($sformatf("Timeout: data access to %03h was never acked", addr));
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        dmem_req = 1'b0;
        dmem_we  = 1'b0;
    endtask

    // Streams count sequential words; the next address is chained onto each ack
    task automatic fetch_words(input mem_bus_pkg::mem_addr_t first, input int count,
                               input int want);
        int                     lat;
        mem_bus_pkg::mem_addr_t cur;
        @(posedge clk);
        #2;
        imem_req  = 1'b1;
        imem_next = (count > 1);
        imem_addr = first;
        for (int k = 0; k < count; k++) begin
            cur = mem_bus_pkg::mem_addr_t'(first + k);
            @(posedge clk);                 // cur sampled here
            fetch_q.push_back(cur);
            #2;
            if (k + 1 < count) begin
                imem_addr = mem_bus_pkg::mem_addr_t'(first + k + 1);
            end else begin
                imem_req  = 1'b0;
                imem_next = 1'b0;
            end
            lat = 1;
            @(negedge clk);
            while (!imem_ack) begin
                if (lat >= FETCH_TIMEOUT)
                    stop_run($sformatf("Timeout: fetch of %03h was never acked", cur));
                lat++;
                @(negedge clk);
            end
            if (want == LAT_HIT)
                assert (lat == 2)
                    else stop_run($sformatf("Fail at %0t ns: fetch %03h took %0d cycles, %s",
                                            $time, cur, lat, "expected a 2 cycle hit"));
            else if (want == LAT_MISS)
                assert (lat > 2)
                    else stop_run($sformatf("Fail at %0t ns: fetch %03h took %0d cycles, %s",
                                            $time, cur, lat, "expected a miss"));
        end
    endtask

    // ************************************************************
    // Compare process
    // ************************************************************

    always @(negedge clk) begin : compare_acks
        mem_bus_pkg::mem_addr_t a;
        logic                   we;
        if (!rst && imem_ack) begin
            assert (fetch_q.size() != 0)
                else stop_run("A fetch ack arrived with no fetch outstanding");
            a = fetch_q.pop_front();
            assert (imem_data === ref_word(a))
                else stop_run($sformatf("Fail at %0t ns: fetch %03h gave %08h, expected %08h",
                                        $time, a, imem_data, ref_word(a)));
        end
        if (!rst && dmem_ack) begin
            assert (dq_addr.size() != 0)
                else stop_run("A data ack arrived with no data access outstanding");
            a  = dq_addr.pop_front();
            we = dq_we.pop_front();
            if (!we)
                assert (dmem_rdata === ref_word(a))
                    else stop_run($sformatf("Fail at %0t ns: read %03h gave %08h, expected %08h",
                                            $time, a, dmem_rdata, ref_word(a)));
        end
    end

    // ************************************************************
    // Stimulus
    // ************************************************************

    initial begin
        mem_bus_pkg::mem_addr_t fa;
        mem_bus_pkg::mem_addr_t da;
        rst        = 1'b1;
        imem_req   = 1'b0;
        imem_addr  = '0;
        imem_next  = 1'b0;
        dmem_req   = 1'b0;
        dmem_we    = 1'b0;
        dmem_addr  = '0;
        dmem_wdata = '0;
        lfsr       = 16'd43;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (!imem_ack && !dmem_ack)
            else stop_run("An ack was active right after reset");

        for (int i = 0; i < 512; i++)
            dmem_access(1'b1, mem_bus_pkg::mem_addr_t'(i), take_bits(32));
        for (int i = 0; i < 512; i++)
            dmem_access(1'b0, mem_bus_pkg::mem_addr_t'(i), '0);

        // Cold misses, tag 0 in every set
        for (int s = 0; s < `CACHE_SETS; s++)
            fetch_words(mem_bus_pkg::mem_addr_t'(line_base(0, s) + take_bits(2)), 1, LAT_MISS);
        for (int s = 0; s < `CACHE_SETS; s++)
            fetch_words(line_base(0, s), `LINE_WORDS, LAT_HIT);

        // Set 31 holds tag 0; tags 1 to 3 fill the other ways, tag 4 evicts tag 0
        for (int w = 0; w < `LINE_WORDS; w++)
            dmem_access(1'b1, mem_bus_pkg::mem_addr_t'(line_base(4, 31) + w), take_bits(32));
        for (int t = 0; t < 4; t++)
            fetch_words(line_base(t, 31), 1, (t == 0) ? LAT_HIT : LAT_MISS);
        for (int t = 0; t < 4; t++)
            fetch_words(mem_bus_pkg::mem_addr_t'(line_base(t, 31) + take_bits(2)), 1, LAT_HIT);
        fetch_words(line_base(4, 31), 1, LAT_MISS);
        fetch_words(mem_bus_pkg::mem_addr_t'(line_base(0, 31) + 1), 1, LAT_MISS);

        // Misses racing data reads for the memory
        for (int i = 0; i < 24; i++) begin
            fa = mem_bus_pkg::mem_addr_t'(line_base(1 + i % 3, i) + take_bits(2));
            da = mem_bus_pkg::mem_addr_t'(take_bits(9));
            fork
                fetch_words(fa, 1, LAT_ANY);
                begin
                    repeat ((i % 2) * 2) @(posedge clk);
                    dmem_access(1'b0, da, '0);
                end
            join
        end

        repeat (4) @(posedge clk);
        if (error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "Checks failed");
        end
    end
endmodule

// ==== verilog/cache_ram.sv ====
module cache_ram #(
    parameter int DEPTH = 32,
    parameter int WIDTH = $bits(icache_pkg::cache_entry_t)
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  icache_pkg::set_idx_t       i_addr,
    input  logic                       i_we,
    input  icache_pkg::cache_entry_t   i_wdata,
    output icache_pkg::cache_entry_t   o_rdata
);
    logic [WIDTH-2:0] store [DEPTH];   // Tag and line
    logic [DEPTH-1:0] valid;

    always_ff @(posedge i_clk) begin
        if (i_we)
            store[i_addr] <= i_wdata[WIDTH-1:1];
        o_rdata <= {store[i_addr], valid[i_addr]};  // Old contents on a write
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            valid <= '0;
        else if (i_we)
            valid[i_addr] <= i_wdata.valid;
    end
endmodule

// ==== verilog/fetch_top.sv ====
`include "cache_cfg.svh"

module fetch_top (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // Instruction fetch
    input  logic                   i_imem_req,
    input  logic [`ADDR_W-1:0]     i_imem_addr,
    input  logic                   i_imem_next,
    output logic                   o_imem_ack,
    output mem_bus_pkg::mem_word_t o_imem_data,

    // Data access
    input  logic                   i_dmem_req,
    input  logic                   i_dmem_we,
    input  mem_bus_pkg::mem_addr_t i_dmem_addr,
    input  mem_bus_pkg::mem_word_t i_dmem_wdata,
    output logic                   o_dmem_ack,
    output mem_bus_pkg::mem_word_t o_dmem_rdata
);
    logic                   ic_req;
    mem_bus_pkg::mem_addr_t ic_addr;
    logic                   ic_ack;
    mem_bus_pkg::mem_word_t ic_data;

    logic                   mem_req;
    logic                   mem_we;
    logic                   mem_burst;
    mem_bus_pkg::mem_addr_t mem_addr;
    mem_bus_pkg::mem_word_t mem_wdata;
    logic                   mem_ack;
    mem_bus_pkg::mem_word_t mem_rdata;

    icache icache_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_imem_req  (i_imem_req),
        .i_imem_addr (i_imem_addr),
        .i_imem_next (i_imem_next),
        .o_imem_ack  (o_imem_ack),
        .o_imem_data (o_imem_data),
        .o_mem_req   (ic_req),
        .o_mem_addr  (ic_addr),
        .i_mem_ack   (ic_ack),
        .i_mem_data  (ic_data)
    );

    mem_arbiter mem_arbiter_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_ic_req    (ic_req),
        .i_ic_addr   (ic_addr),
        .o_ic_ack    (ic_ack),
        .o_ic_data   (ic_data),
        .i_d_req     (i_dmem_req),
        .i_d_we      (i_dmem_we),
        .i_d_addr    (i_dmem_addr),
        .i_d_wdata   (i_dmem_wdata),
        .o_d_ack     (o_dmem_ack),
        .o_d_rdata   (o_dmem_rdata),
        .o_mem_req   (mem_req),
        .o_mem_we    (mem_we),
        .o_mem_burst (mem_burst),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata)
    );

    main_mem main_mem_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (mem_req),
        .i_we    (mem_we),
        .i_burst (mem_burst),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_ack   (mem_ack),
        .o_rdata (mem_rdata)
    );
endmodule

// ==== verilog/icache.sv ====
`include "cache_cfg.svh"

module icache (
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  logic                   i_imem_req,
    input  logic [`ADDR_W-1:0]     i_imem_addr,
    input  logic                   i_imem_next,
    output logic                   o_imem_ack,
    output mem_bus_pkg::mem_word_t o_imem_data,

    output logic                   o_mem_req,
    output mem_bus_pkg::mem_addr_t o_mem_addr,
    input  logic                   i_mem_ack,
    input  mem_bus_pkg::mem_word_t i_mem_data
);
    localparam int WAY_W = $clog2(`CACHE_WAYS);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LOOKUP = 2'd1;
    localparam logic [1:0] ST_FILL   = 2'd2;
    localparam logic [1:0] ST_WRITE  = 2'd3;

    logic [1:0]                                 state;
    icache_pkg::fetch_addr_u                    in_addr;
    icache_pkg::fetch_addr_u                    req_addr;
    logic                                       take;
    logic [`OFF_W-1:0]                          beat_cnt;
    mem_bus_pkg::mem_word_t [`LINE_WORDS-1:0]   line_buf;
    logic                                       reread;
    logic [WAY_W-1:0]                           victim;
    logic [WAY_W-1:0]                           rr_ptr [`CACHE_SETS];

    icache_pkg::set_idx_t                       ram_addr;
    icache_pkg::cache_entry_t                   ram_wdata;
    icache_pkg::cache_entry_t                   ram_rdata [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]                     ram_we;
    logic [`CACHE_WAYS-1:0]                     valid_vec;
    logic [`CACHE_WAYS-1:0]                     hit_vec;
    mem_bus_pkg::mem_word_t [`LINE_WORDS-1:0]   hit_line;
    logic                                       free_found;
    logic [WAY_W-1:0]                           free_way;

    assign in_addr = i_imem_addr;

    // New request when idle, or chained onto an ack with next
    assign take = i_imem_req && (!o_imem_ack || i_imem_next);

    // Idle reads the incoming set so lookup sees it one cycle later
    assign ram_addr = (state == ST_IDLE) ? in_addr.f.idx : req_addr.f.idx;

    assign ram_wdata.tag   = req_addr.f.tag;
    assign ram_wdata.line  = line_buf;
    assign ram_wdata.valid = 1'b1;

    assign o_mem_addr = {req_addr.b.line, `OFF_W'(0)};   // Line base, beat 0

    // ************************************************************
    // Ways
    // ************************************************************

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        assign ram_we[w] = (state == ST_WRITE) && !reread && (victim == WAY_W'(w));

        cache_ram #(
            .DEPTH (`CACHE_SETS),
            .WIDTH ($bits(icache_pkg::cache_entry_t))
        ) cache_ram_i (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_addr  (ram_addr),
            .i_we    (ram_we[w]),
            .i_wdata (ram_wdata),
            .o_rdata (ram_rdata[w])
        );

        assign valid_vec[w] = ram_rdata[w].valid;
        assign hit_vec[w]   = ram_rdata[w].valid && (ram_rdata[w].tag == req_addr.f.tag);
    end

    // Hit vector is one-hot, so an OR of the hitting lines selects the way
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hit_vec[w])
                hit_line = hit_line | ram_rdata[w].line;
        end
    end

    // Lowest invalid way
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                free_found = 1'b1;
                free_way   = WAY_W'(w);
            end
        end
    end

    // ************************************************************
    // Control
    // ************************************************************

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            o_imem_ack <= 1'b0;
            o_mem_req  <= 1'b0;
            beat_cnt   <= '0;
            reread     <= 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++)
                rr_ptr[s] <= '0;
        end else begin
            o_imem_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take)
                        state <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (|hit_vec) begin
                        o_imem_ack <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        o_mem_req <= 1'b1;      // Held through the fourth ack
                        beat_cnt  <= '0;
                        state     <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (i_mem_ack) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (&beat_cnt) begin
                            o_mem_req <= 1'b0;
                            reread    <= 1'b0;
                            state     <= ST_WRITE;
                        end
                    end
                end
                default: begin
                    // Write cycle, then one cycle for the RAM to read it back
                    if (!reread) begin
                        reread                 <= 1'b1;
                        rr_ptr[req_addr.f.idx] <= victim + 1'b1;
                    end else begin
                        state <= ST_LOOKUP;
                    end
                end
            endcase
        end
    end

    // Address, fill buffer and read data
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && take)
            req_addr <= in_addr;
        if (state == ST_LOOKUP && (|hit_vec))
            o_imem_data <= hit_line[req_addr.f.off];
        if (state == ST_LOOKUP && !(|hit_vec))
            victim <= free_found ? free_way : rr_ptr[req_addr.f.idx];
        if (state == ST_FILL && i_mem_ack)
            line_buf[beat_cnt] <= i_mem_data;
    end
endmodule

// ==== verilog/icache_pkg.sv ====
`include "cache_cfg.svh"

package icache_pkg;

    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`SET_W-1:0] set_idx_t;

    // Fetch address, read for lookup or for the line burst
    typedef union packed {
        struct packed {
            tag_t                tag;
            set_idx_t            idx;
            logic [`OFF_W-1:0]   off;
        } f;
        struct packed {
            logic [`LINE_ADDR_W-1:0] line;
            logic [`OFF_W-1:0]       beat;
        } b;
    } fetch_addr_u;

    // One way of one set: tag, four words, valid in bit 0
    typedef struct packed {
        tag_t                                       tag;
        mem_bus_pkg::mem_word_t [`LINE_WORDS-1:0]   line;
        logic                                       valid;
    } cache_entry_t;

endpackage

// ==== verilog/main_mem.sv ====
`include "cache_cfg.svh"

module main_mem (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_req,
    input  logic                   i_we,
    input  logic                   i_burst,
    input  mem_bus_pkg::mem_addr_t i_addr,
    input  mem_bus_pkg::mem_word_t i_wdata,
    output logic                   o_ack,
    output mem_bus_pkg::mem_word_t o_rdata
);
    localparam int LAT_W  = $clog2(`MEM_LATENCY + 1);
    localparam int BEAT_W = $clog2(`LINE_WORDS);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    mem_bus_pkg::mem_word_t mem [`MEM_DEPTH];

    logic [1:0]             state;
    logic [LAT_W-1:0]       lat_cnt;
    logic [BEAT_W-1:0]      beat;
    logic                   we_q;
    logic                   burst_q;
    mem_bus_pkg::mem_addr_t addr_q;
    mem_bus_pkg::mem_addr_t cur_addr;
    mem_bus_pkg::mem_word_t wdata_q;
    logic                   xfer;
    logic                   last_beat;

    // Burst beats step through the line from beat 0
    assign cur_addr  = burst_q ? {addr_q[`ADDR_W-1:BEAT_W], beat} : addr_q;
    assign xfer      = (state == ST_BUSY) && (lat_cnt == '0);
    assign last_beat = !burst_q || (beat == BEAT_W'(`LINE_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_IDLE;
            o_ack   <= 1'b0;
            lat_cnt <= '0;
            beat    <= '0;
        end else begin
            o_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        lat_cnt <= LAT_W'(`MEM_LATENCY - 1);
                        beat    <= '0;
                        state   <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (lat_cnt != '0) begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end else begin
                        o_ack <= 1'b1;
                        beat  <= beat + 1'b1;
                        if (last_beat)
                            state <= ST_DONE;
                    end
                end
                default: begin
                    if (!i_req)                 // Wait for the requester to let go
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_req) begin
            addr_q  <= i_addr;
            we_q    <= i_we;
            burst_q <= i_burst;
            wdata_q <= i_wdata;
        end
        if (xfer) begin
            if (we_q && !burst_q)
                mem[cur_addr] <= wdata_q;
            o_rdata <= mem[cur_addr];
        end
    end
endmodule

// ==== verilog/mem_arbiter.sv ====
module mem_arbiter (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // Instruction cache, burst reads only
    input  logic                   i_ic_req,
    input  mem_bus_pkg::mem_addr_t i_ic_addr,
    output logic                   o_ic_ack,
    output mem_bus_pkg::mem_word_t o_ic_data,

    // Data port, single words
    input  logic                   i_d_req,
    input  logic                   i_d_we,
    input  mem_bus_pkg::mem_addr_t i_d_addr,
    input  mem_bus_pkg::mem_word_t i_d_wdata,
    output logic                   o_d_ack,
    output mem_bus_pkg::mem_word_t o_d_rdata,

    // Shared memory
    output logic                   o_mem_req,
    output logic                   o_mem_we,
    output logic                   o_mem_burst,
    output mem_bus_pkg::mem_addr_t o_mem_addr,
    output mem_bus_pkg::mem_word_t o_mem_wdata,
    input  logic                   i_mem_ack,
    input  mem_bus_pkg::mem_word_t i_mem_rdata
);
    mem_bus_pkg::grant_e owner;
    logic                last_ic;   // Cache was served last
    logic                own_ic;
    logic                own_d;

    assign own_ic = (owner == mem_bus_pkg::GRANT_ICACHE);
    assign own_d  = (owner == mem_bus_pkg::GRANT_DATA);

    // Grant is held until the owner drops req
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner   <= mem_bus_pkg::GRANT_NONE;
            last_ic <= 1'b0;
        end else begin
            case (owner)
                mem_bus_pkg::GRANT_ICACHE: begin
                    if (!i_ic_req)
                        owner <= mem_bus_pkg::GRANT_NONE;
                end
                mem_bus_pkg::GRANT_DATA: begin
                    if (!i_d_req)
                        owner <= mem_bus_pkg::GRANT_NONE;
                end
                default: begin
                    if (i_ic_req && (!i_d_req || !last_ic)) begin
                        owner   <= mem_bus_pkg::GRANT_ICACHE;
                        last_ic <= 1'b1;
                    end else if (i_d_req) begin
                        owner   <= mem_bus_pkg::GRANT_DATA;
                        last_ic <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign o_mem_req   = (own_ic && i_ic_req) || (own_d && i_d_req);
    assign o_mem_we    = own_d && i_d_we;
    assign o_mem_burst = own_ic;
    assign o_mem_addr  = own_d ? i_d_addr : i_ic_addr;
    assign o_mem_wdata = own_d ? i_d_wdata : '0;

    assign o_ic_ack  = own_ic && i_mem_ack;     // Only the owner sees the ack
    assign o_ic_data = i_mem_rdata;
    assign o_d_ack   = own_d && i_mem_ack;
    assign o_d_rdata = i_mem_rdata;
endmodule

// ==== verilog/mem_bus_pkg.sv ====
`include "cache_cfg.svh"

package mem_bus_pkg;

    // One word of the shared memory
    typedef logic [`DATA_W-1:0] mem_word_t;

    // Word address into the shared memory
    typedef logic [`ADDR_W-1:0] mem_addr_t;

    // Current owner of the memory port
    typedef enum logic [1:0] {
        GRANT_NONE   = 2'd0,
        GRANT_ICACHE = 2'd1,
        GRANT_DATA   = 2'd2
    } grant_e;

endpackage
